// File: vlog.f
source/fabric_pkg.sv
source/fabric_decode.sv
source/fabric_execute.sv
source/fabric_result.sv
source/caliptra_fabric_top.sv
dv/fabric_sva.sv
dv/fabric_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the fabric testbench with Verilator.
# The simulator exits nonzero on any $fatal, which fails this script.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module fabric_tb \
    -o fabric_sim

./obj_dir/fabric_sim

// File: dv/fabric_tb.sv
// Random traffic against a reference model that is updated when each request is accepted.
// Assumes BANK_WORDS of 16, so every bank offset in addr[5:2] is mapped.
`timescale 1ns/10ps

module fabric_tb
    import fabric_pkg::*;
();

    localparam int BANK_WORDS = 16;
    localparam int TIMEOUT    = 200;   // Cycles per wait loop

    logic                clk;
    logic                rst_i;
    logic                req_valid_i;
    logic                req_ready_o;
    fabric_req_t         req_i;
    logic                rsp_valid_o;
    logic                rsp_ready_i;
    fabric_rsp_t         rsp_o;
    logic                intr_clr_i;
    logic [NUM_INTR-1:0] intr_o;
    logic [DATA_W-1:0]   generic_o;

    // Reference model with bank 0 as IDMA and bank 1 as DDMA
    logic [DATA_W-1:0]   m_bank [2][BANK_WORDS];
    logic                m_lock;
    logic [DATA_W-1:0]   m_generic;
    logic [NUM_INTR-1:0] m_intr;
    fabric_rsp_t         exp_q [$];

    caliptra_fabric_top #(
        .BANK_WORDS (BANK_WORDS)
    ) i_caliptra_fabric_top (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_i       (req_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_o       (rsp_o),
        .intr_clr_i  (intr_clr_i),
        .intr_o      (intr_o),
        .generic_o   (generic_o)
    );

    bind caliptra_fabric_top fabric_sva i_fabric_sva (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_i       (req_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_o       (rsp_o),
        .intr_o      (intr_o),
        .generic_o   (generic_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ========================================
    // Helpers
    // ========================================
    task automatic check_eq(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                            input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Some tests failed");
            $fatal(1, "Value mismatch on %s", what);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Waited %0d cycles for %s and gave up", TIMEOUT, what);
        $display("Some tests failed");
        $fatal(1, "Timeout");
    endtask

    // Advance one cycle and drive inputs 1 ns after the edge
    task automatic step_cycle();
        @(posedge clk);
        #1;
        rsp_ready_i = ($urandom % 10) >= 3;   // Back-pressure about 30%
    endtask

    task automatic model_apply(input op_e op, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] wdata);
        logic [1:0]  slot;
        logic [3:0]  off;
        logic        bank_idx;
        logic        unmapped;
        fabric_rsp_t exp;
        slot     = addr[11:10];
        off      = addr[5:2];
        bank_idx = (slot == SLOT_DDMA);
        unmapped = (slot == SLOT_TIEOFF) || (addr[9:6] != 4'd0)
                   || (slot == SLOT_CTRL && int'(off) >= CTRL_WORDS)
                   || (slot != SLOT_CTRL && int'(off) >= BANK_WORDS);
        exp = '0;
        if (unmapped) begin
            exp.err = 1'b1;
            m_intr[VEC_DECODE_ERR-1] = 1'b1;
        end else if (slot == SLOT_IDMA && m_lock) begin
            exp.err = 1'b1;
            m_intr[VEC_BLOCKED-1] = 1'b1;
        end else if (op == OP_WRITE) begin
            m_intr[VEC_WRITE_NOTIF-1] = 1'b1;
            if (slot != SLOT_CTRL) m_bank[bank_idx][off] = wdata;
            else if (off == REG_LOCK) m_lock = m_lock | wdata[0];
            else m_generic = wdata;
        end else begin
            if (slot != SLOT_CTRL) exp.rdata = m_bank[bank_idx][off];
            else if (off == REG_LOCK) exp.rdata = DATA_W'(m_lock);
            else exp.rdata = m_generic;
        end
        exp_q.push_back(exp);
    endtask

    // Starts 1 ns after an edge and returns 1 ns after the accepting edge
    task automatic send_req(input op_e op, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata);
        int waited;
        waited      = 0;
        req_i.op    = op;
        req_i.addr  = addr;
        req_i.wdata = wdata;
        req_valid_i = 1'b1;
        @(negedge clk);
        while (!req_ready_o && waited < TIMEOUT) begin
            step_cycle();
            @(negedge clk);
            waited++;
        end
        if (!req_ready_o) begin
            timeout_fail("req_ready_o");
        end else begin
            model_apply(op, addr, wdata);   // Taken at the next rising edge
            step_cycle();
            req_valid_i = 1'b0;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while ((exp_q.size() != 0 || rsp_valid_o) && waited < TIMEOUT) begin
            step_cycle();
            waited++;
        end
        if (exp_q.size() != 0 || rsp_valid_o) timeout_fail("the pipeline to drain");
    endtask

    task automatic clear_intr();
        intr_clr_i = 1'b1;
        step_cycle();
        intr_clr_i = 1'b0;
        m_intr     = '0;
        check_eq(DATA_W'(intr_o), '0, "intr_o after clear");
    endtask

    task automatic random_traffic(input int count);
        int                pick;
        logic [3:0]        off;
        logic [ADDR_W-1:0] addr;
        op_e               op;
        logic [DATA_W-1:0] wdata;
        for (int i = 0; i < count; i++) begin
            pick  = $urandom_range(0, 99);
            off   = 4'($urandom_range(0, 15));
            op    = (($urandom % 2) == 1) ? OP_WRITE : OP_READ;
            wdata = $urandom;
            if (pick < 40) begin
                addr = {SLOT_DDMA, 4'h0, off, 2'($urandom_range(0, 3))};
            end else if (pick < 75) begin
                addr = {SLOT_IDMA, 4'h0, off, 2'($urandom_range(0, 3))};
            end else if (pick < 88) begin
                addr = {SLOT_CTRL, 4'h0, REG_GENERIC, 2'b00};
            end else if (pick < 91) begin
                addr = {SLOT_CTRL, 4'h0, REG_LOCK, 2'b00};
                op   = OP_READ;   // Lock set only by the directed write
            end else if (pick < 94) begin
                addr = {SLOT_TIEOFF, 4'h0, off, 2'b00};
            end else if (pick < 97) begin
                addr = {2'($urandom_range(0, 2)), 4'($urandom_range(1, 15)), off, 2'b00};
            end else begin
                addr = {SLOT_CTRL, 4'h0, 4'($urandom_range(2, 15)), 2'b00};
            end
            send_req(op, addr, wdata);
            if ($urandom_range(0, 3) == 0) step_cycle();   // Idle gap
        end
    endtask

    // Response checker sampling in the falling half before the handshake edge
    always @(negedge clk) begin
        fabric_rsp_t exp_rsp;
        if (!rst_i && rsp_valid_o && rsp_ready_i) begin
            if (exp_q.size() == 0) begin
                $display("A response arrived with no request outstanding");
                $display("Some tests failed");
                $fatal(1, "Unexpected response");
            end else begin
                exp_rsp = exp_q.pop_front();
                check_eq(DATA_W'(rsp_o.err), DATA_W'(exp_rsp.err), "rsp_o.err");
                check_eq(rsp_o.rdata, exp_rsp.rdata, "rsp_o.rdata");
            end
        end
    end

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        void'($urandom(32'h9122));
        rst_i       = 1'b1;
        req_valid_i = 1'b0;
        req_i       = '0;
        rsp_ready_i = 1'b0;
        intr_clr_i  = 1'b0;
        m_lock      = 1'b0;
        m_generic   = '0;
        m_intr      = '0;
        for (int b = 0; b < 2; b++) begin
            for (int w = 0; w < BANK_WORDS; w++) m_bank[b][w] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst_i = 1'b0;

        // Open traffic with the lock still clear
        random_traffic(300);
        drain();
        check_eq(generic_o, m_generic, "generic_o");
        check_eq(DATA_W'(intr_o), DATA_W'(m_intr), "intr_o after open traffic");
        clear_intr();

        // Decode errors only
        send_req(OP_READ, {SLOT_TIEOFF, 4'h0, 4'h5, 2'b00}, '0);
        send_req(OP_WRITE, {SLOT_DDMA, 4'h5, 4'h3, 2'b00}, 32'hdead_beef);
        send_req(OP_READ, {SLOT_CTRL, 4'h0, 4'h2, 2'b00}, '0);
        send_req(OP_WRITE, {SLOT_CTRL, 4'h0, 4'hf, 2'b00}, 32'hffff_ffff);
        send_req(OP_READ, {SLOT_DDMA, 4'h0, 4'h3, 2'b00}, '0);
        drain();
        check_eq(DATA_W'(intr_o), 32'h1, "intr_o after decode errors");
        clear_intr();

        // A lock write with bit 0 clear does nothing before the real lock
        send_req(OP_WRITE, {SLOT_CTRL, 4'h0, REG_LOCK, 2'b00}, 32'hffff_fffe);
        send_req(OP_READ, {SLOT_CTRL, 4'h0, REG_LOCK, 2'b00}, '0);
        send_req(OP_WRITE, {SLOT_CTRL, 4'h0, REG_LOCK, 2'b00}, $urandom | 32'h1);
        drain();
        check_eq(DATA_W'(intr_o), 32'h4, "intr_o after lock write");
        clear_intr();

        random_traffic(300);
        for (int w = 0; w < BANK_WORDS; w++) begin
            send_req(OP_READ, {SLOT_IDMA, 4'h0, 4'(w), 2'b00}, '0);
            send_req(OP_READ, {SLOT_DDMA, 4'h0, 4'(w), 2'b00}, '0);
        end
        drain();
        check_eq(DATA_W'(intr_o[VEC_BLOCKED-1]), 32'h1, "blocked interrupt bit");
        check_eq(DATA_W'(intr_o), DATA_W'(m_intr), "intr_o after locked traffic");
        check_eq(generic_o, m_generic, "generic_o");

        $display("All tests passed");
        $finish;
    end

endmodule

// File: dv/fabric_sva.sv
// Port checks bound into the fabric top. X-checks only bite on a four-state simulator.
`timescale 1ns/10ps

module fabric_sva
    import fabric_pkg::*;
(
    input logic                clk,
    input logic                rst_i,
    input logic                req_valid_i,
    input logic                req_ready_o,
    input fabric_req_t         req_i,
    input logic                rsp_valid_o,
    input logic                rsp_ready_i,
    input fabric_rsp_t         rsp_o,
    input logic [NUM_INTR-1:0] intr_o,
    input logic [DATA_W-1:0]   generic_o
);

    // ========================================
    // Known values
    // ========================================
    out_known_a: assert property (@(posedge clk) disable iff (rst_i)
        !$isunknown({req_ready_o, rsp_valid_o, rsp_o, intr_o, generic_o}))
        else $error("Fabric output is X after reset");

    req_known_a: assert property (@(posedge clk) disable iff (rst_i)
        !$isunknown(req_valid_i) && (!req_valid_i || !$isunknown(req_i)))
        else $error("Request valid or payload is X");

    // ========================================
    // Handshake stability
    // ========================================
    rsp_hold_a: assert property (@(posedge clk) disable iff (rst_i)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
        else $error("Response changed while waiting for rsp_ready_i");

    req_hold_a: assert property (@(posedge clk) disable iff (rst_i)
        req_valid_i && !req_ready_o |=> req_valid_i && $stable(req_i))
        else $error("Request changed while waiting for req_ready_o");

endmodule

// File: source/caliptra_fabric_top.sv
// Three-stage bus fabric with one global stall from the response port.
// Bubbles are not squeezed out, so back-pressure freezes the whole pipe.
`timescale 1ns/10ps

module caliptra_fabric_top
    import fabric_pkg::*;
#(
    parameter int BANK_WORDS = 16
) (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                req_valid_i,
    output logic                req_ready_o,
    input  fabric_req_t         req_i,
    output logic                rsp_valid_o,
    input  logic                rsp_ready_i,
    output fabric_rsp_t         rsp_o,
    input  logic                intr_clr_i,
    output logic [NUM_INTR-1:0] intr_o,
    output logic [DATA_W-1:0]   generic_o
);

    logic              stall;      // Response waiting and not taken
    logic              dec_valid;
    decoded_t          dec_q;
    logic              exe_valid;
    decoded_t          exe_q;
    logic [DATA_W-1:0] exe_rdata;
    logic              exe_blocked;

    assign stall       = rsp_valid_o & ~rsp_ready_i;
    assign req_ready_o = ~stall;

    // ========================================
    // Pipeline stages
    // ========================================
    fabric_decode #(
        .BANK_WORDS  (BANK_WORDS)
    ) i_fabric_decode (
        .clk         (clk),
        .rst_i       (rst_i),
        .stall_i     (stall),
        .in_valid_i  (req_valid_i),
        .in_i        (req_i),
        .out_valid_o (dec_valid),
        .out_o       (dec_q)
    );

    fabric_execute #(
        .BANK_WORDS  (BANK_WORDS)
    ) i_fabric_execute (
        .clk         (clk),
        .rst_i       (rst_i),
        .stall_i     (stall),
        .in_valid_i  (dec_valid),
        .in_i        (dec_q),
        .out_valid_o (exe_valid),
        .out_o       (exe_q),
        .rdata_o     (exe_rdata),
        .blocked_o   (exe_blocked),
        .generic_o   (generic_o)
    );

    fabric_result i_fabric_result (
        .clk         (clk),
        .rst_i       (rst_i),
        .stall_i     (stall),
        .in_valid_i  (exe_valid),
        .in_i        (exe_q),
        .rdata_i     (exe_rdata),
        .blocked_i   (exe_blocked),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o),
        .intr_clr_i  (intr_clr_i),
        .intr_o      (intr_o)
    );

endmodule

// File: source/fabric_result.sv
// Result stage driving the response port and the sticky interrupt bits.
// Interrupt bits clear together on intr_clr_i; a new set wins over the clear.
`timescale 1ns/10ps

module fabric_result
    import fabric_pkg::*;
(
    input  logic                clk,
    input  logic                rst_i,
    input  logic                stall_i,
    input  logic                in_valid_i,
    input  decoded_t            in_i,
    input  logic [DATA_W-1:0]   rdata_i,
    input  logic                blocked_i,
    output logic                rsp_valid_o,
    output fabric_rsp_t         rsp_o,
    input  logic                intr_clr_i,
    output logic [NUM_INTR-1:0] intr_o
);

    logic                advance;
    logic                err;
    logic [NUM_INTR-1:0] intr_set;
    logic [NUM_INTR-1:0] intr_q;

    // ========================================
    // Response and interrupt causes
    // ========================================
    always_comb begin
        advance = in_valid_i && !stall_i;
        err     = in_i.unmapped | blocked_i;

        intr_set = '0;
        if (advance) begin
            intr_set[VEC_DECODE_ERR-1]  = in_i.unmapped;
            intr_set[VEC_BLOCKED-1]     = blocked_i;
            intr_set[VEC_WRITE_NOTIF-1] = (in_i.op == OP_WRITE) && !err;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rsp_valid_o <= 1'b0;
        end else if (!stall_i) begin
            rsp_valid_o <= in_valid_i;
        end
    end

    // Output register keeps the last response while idle
    always_ff @(posedge clk) begin
        if (rst_i) begin
            rsp_o <= '0;
        end else if (advance) begin
            rsp_o.err   <= err;
            rsp_o.rdata <= (in_i.op == OP_WRITE) ? '0 : rdata_i;
        end
    end

    // Sticky status
    always_ff @(posedge clk) begin
        if (rst_i) begin
            intr_q <= '0;
        end else begin
            intr_q <= (intr_clr_i ? '0 : intr_q) | intr_set;
        end
    end

    assign intr_o = intr_q;

endmodule

// File: source/fabric_execute.sv
// Execute stage with control register, IDMA lock and both data banks.
// The lock is sticky until reset; blocked IDMA writes are dropped.
`timescale 1ns/10ps

module fabric_execute
    import fabric_pkg::*;
#(
    parameter int BANK_WORDS = 16
) (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              stall_i,
    input  logic              in_valid_i,
    input  decoded_t          in_i,
    output logic              out_valid_o,
    output decoded_t          out_o,
    output logic [DATA_W-1:0] rdata_o,
    output logic              blocked_o,
    output logic [DATA_W-1:0] generic_o
);

    // Index 0 is the IDMA bank, index 1 the DDMA bank
    logic [DATA_W-1:0] bank_mem [2][BANK_WORDS];

    logic              lock_q;
    logic [DATA_W-1:0] generic_q;

    logic              advance;
    logic              bank_sel;
    logic              is_bank;
    logic              blocked;
    logic              do_write;
    logic [DATA_W-1:0] rdata_next;

    // ========================================
    // Access decision and read mux
    // ========================================
    always_comb begin
        advance  = in_valid_i && !stall_i;
        bank_sel = (in_i.slot == SLOT_DDMA);
        is_bank  = (in_i.slot == SLOT_IDMA) || (in_i.slot == SLOT_DDMA);
        blocked  = !in_i.unmapped && (in_i.slot == SLOT_IDMA) && lock_q;
        do_write = advance && (in_i.op == OP_WRITE) && !in_i.unmapped && !blocked;

        rdata_next = '0;   // Unmapped and blocked reads return zero
        if (!in_i.unmapped && !blocked && in_i.op == OP_READ) begin
            if (is_bank) begin
                rdata_next = bank_mem[bank_sel][in_i.offset];
            end else if (in_i.offset == REG_LOCK) begin
                rdata_next = DATA_W'(lock_q);
            end else begin
                rdata_next = generic_q;
            end
        end
    end

    // Data banks come out of reset cleared
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int b = 0; b < 2; b++) begin
                for (int w = 0; w < BANK_WORDS; w++) begin
                    bank_mem[b][w] <= '0;
                end
            end
        end else if (do_write && is_bank) begin
            bank_mem[bank_sel][in_i.offset] <= in_i.wdata;
        end
    end

    // ========================================
    // Control responder
    // ========================================
    always_ff @(posedge clk) begin
        if (rst_i) begin
            lock_q    <= 1'b0;
            generic_q <= '0;
        end else if (do_write && in_i.slot == SLOT_CTRL) begin
            if (in_i.offset == REG_LOCK) begin
                lock_q <= lock_q | in_i.wdata[0];   // Set only, never cleared
            end else begin
                generic_q <= in_i.wdata;
            end
        end
    end

    assign generic_o = generic_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            out_valid_o <= 1'b0;
        end else if (!stall_i) begin
            out_valid_o <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            out_o     <= in_i;
            rdata_o   <= rdata_next;
            blocked_o <= blocked;
        end
    end

endmodule

// File: source/fabric_decode.sv
// Decode stage. Address bits 1:0 are ignored; bits 9:6 must be zero.
`timescale 1ns/10ps

module fabric_decode
    import fabric_pkg::*;
#(
    parameter int BANK_WORDS = 16
) (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        stall_i,
    input  logic        in_valid_i,
    input  fabric_req_t in_i,
    output logic        out_valid_o,
    output decoded_t    out_o
);

    slot_e             slot;
    logic [OFFS_W-1:0] offset;
    logic              hole;       // Nonzero bits between slot and offset
    logic              too_deep;   // Offset past the end of the responder
    logic              unmapped;

    // ========================================
    // Address split
    // ========================================
    always_comb begin
        slot   = slot_e'(in_i.addr[ADDR_W-1 -: SLOT_W]);
        offset = in_i.addr[OFFS_W+1:2];
        hole   = |in_i.addr[ADDR_W-SLOT_W-1:OFFS_W+2];

        case (slot)
            SLOT_CTRL:           too_deep = int'(offset) >= CTRL_WORDS;
            SLOT_IDMA,
            SLOT_DDMA:           too_deep = int'(offset) >= BANK_WORDS;
            default:             too_deep = 1'b0;   // Tie-off handled below
        endcase

        unmapped = hole | too_deep | (slot == SLOT_TIEOFF);
    end

    // ========================================
    // Stage register
    // ========================================
    always_ff @(posedge clk) begin
        if (rst_i) begin
            out_valid_o <= 1'b0;
        end else if (!stall_i) begin
            out_valid_o <= in_valid_i;
        end
    end

    // Payload only loads on an accepted request
    always_ff @(posedge clk) begin
        if (!stall_i && in_valid_i) begin
            out_o.op       <= in_i.op;
            out_o.slot     <= slot;
            out_o.offset   <= offset;
            out_o.wdata    <= in_i.wdata;
            out_o.unmapped <= unmapped;
        end
    end

endmodule

// File: source/fabric_pkg.sv
// Shared widths, address map and bus structs of the fabric.
// The address map assumes a 12-bit byte address with the slot in bits 11:10.
package fabric_pkg;

    // ========================================
    // Widths and address map
    // ========================================
    localparam int ADDR_W     = 12;   // Byte address
    localparam int DATA_W     = 32;
    localparam int SLOT_W     = 2;    // Slot sits in addr[11:10]
    localparam int OFFS_W     = 4;    // Word offset in addr[5:2]
    localparam int CTRL_WORDS = 2;    // Words behind the control responder
    localparam int NUM_INTR   = 3;

    // Responder slots
    typedef enum logic [SLOT_W-1:0] {
        SLOT_CTRL   = 2'd0,
        SLOT_IDMA   = 2'd1,   // Lockable instruction-memory bank
        SLOT_DDMA   = 2'd2,
        SLOT_TIEOFF = 2'd3    // Nothing behind it, always errors
    } slot_e;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } op_e;

    // Control responder word offsets
    typedef enum logic [OFFS_W-1:0] {
        REG_LOCK    = 4'd0,   // Bit 0 is sticky once written as 1
        REG_GENERIC = 4'd1
    } ctrl_reg_e;

    // Vector 0 is reserved, so vector v lands on intr bit v-1
    typedef enum int {
        VEC_DECODE_ERR  = 1,
        VEC_BLOCKED     = 2,
        VEC_WRITE_NOTIF = 3
    } intr_vec_e;

    // ========================================
    // Structs
    // ========================================
    typedef struct packed {
        op_e               op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } fabric_req_t;

    typedef struct packed {
        op_e               op;
        slot_e             slot;
        logic [OFFS_W-1:0] offset;
        logic [DATA_W-1:0] wdata;
        logic              unmapped;   // No responder at this address
    } decoded_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              err;
    } fabric_rsp_t;

endpackage
